// ==== Bender.yml ====
package:
  name: decode_execute

sources:
  - rv_pipe_pkg.sv
  - id_ex_if.sv
  - reg_file.sv
  - imm_gen.sv
  - hazard_control.sv
  - id_ex_reg.sv
  - execute_stage.sv
  - decode_execute_top.sv
  - target: test
    files:
      - tb_decode_execute.sv

// ==== decode_execute.f ====
rv_pipe_pkg.sv
id_ex_if.sv
reg_file.sv
imm_gen.sv
hazard_control.sv
id_ex_reg.sv
execute_stage.sv
decode_execute_top.sv
tb_decode_execute.sv

// ==== decode_execute_cases.txt ====
// One row per cycle: instr _ pc_in _ wb_regwrite _ wb_rd _ wb_data _ stall _ pcsrc
// _ branch_target _ ex regwrite/memread/memwrite/memtoreg _ ex_rd _ ex_result _ store
// Preload x1 = 5, x2 = 3, x3 = -16 through the writeback port.
00000000_00000000_1_01_00000005_0_0_00000000_0000_00_00000000_00000000
00000000_00000000_1_02_00000003_0_0_00000000_0000_00_00000000_00000000
00000000_00000000_1_03_fffffff0_0_0_00000000_0000_00_00000000_00000000
// add, addi, sub, slt, sll, srl, xori, ori with forwarding and bypass.
00208233_00000100_0_00_00000000_0_0_00000000_0000_00_00000000_00000000
00220213_00000104_0_00_00000000_0_0_00000100_0000_00_00000000_00000000
401202b3_00000108_0_00_00000000_0_0_00000106_1000_04_00000008_00000003
0011a333_0000010c_1_04_00000008_0_0_00000108_1000_04_0000000a_00000003
002293b3_00000110_1_04_0000000a_0_0_0000010c_1000_05_00000005_00000005
0021d433_00000114_1_05_00000005_0_0_00000110_1000_06_00000001_00000005
0ff34493_00000118_1_06_00000001_0_0_00000114_1000_07_00000028_00000003
1004e513_0000011c_1_07_00000028_0_0_00000217_1000_08_1ffffffe_00000003
// sw, lw, then a dependent add that stalls for one cycle.
00a0a423_00000120_1_08_1ffffffe_0_0_0000021c_1000_09_000000fe_00000000
00412583_00000124_1_09_000000fe_0_0_00000128_1000_0a_000001fe_00000000
00158633_00000128_1_0a_000001fe_1_0_00000128_0010_08_0000000d_000001fe
00158633_00000128_0_00_00000000_0_0_00000000_1101_0b_00000007_0000000a
// beq not taken, addi, beq taken, squashed add, add at the target.
00160463_0000012c_1_0b_00001000_0_0_00000128_0000_00_00000000_00000000
00700693_00000130_0_00_00000000_0_0_00000134_1000_0c_00001005_00000005
02d68063_00000134_1_0c_00001005_0_0_00000137_0000_08_00001000_00000005
00108733_00000138_0_00_00000000_0_1_00000154_1000_0d_00000007_00000028
00d607b3_00000154_1_0d_00000007_0_0_00000000_0000_00_00000000_00000007
00000000_00000000_0_00_00000000_0_0_00000154_0000_00_00000000_00000000
00000000_00000000_0_00_00000000_0_0_00000000_1000_0f_0000100c_00000007

// ==== decode_execute_top.sv ====
`timescale 1ns/1ps

module decode_execute_top (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::instr_t    instr,
    input  rv_pipe_pkg::word_t     pc_in,
    input  logic                   wb_regwrite,
    input  rv_pipe_pkg::reg_addr_t wb_rd,
    input  rv_pipe_pkg::word_t     wb_data,
    output logic                   stall,
    output logic                   pcsrc,
    output rv_pipe_pkg::word_t     branch_target,
    output logic                   ex_regwrite,
    output logic                   ex_memread,
    output logic                   ex_memwrite,
    output logic                   ex_memtoreg,
    output rv_pipe_pkg::reg_addr_t ex_rd,
    output rv_pipe_pkg::word_t     ex_result,
    output rv_pipe_pkg::word_t     ex_store_data
);

    // Decode-side fields
    logic                dec_branch;
    logic                dec_memread;
    logic                dec_memtoreg;
    logic                dec_memwrite;
    logic                dec_alusrc;
    logic                dec_regwrite;
    rv_pipe_pkg::aluop_t dec_aluop;
    rv_pipe_pkg::word_t  rf_a;
    rv_pipe_pkg::word_t  rf_b;
    rv_pipe_pkg::word_t  imm;
    logic                bubble;

    id_ex_if idex ();

    reg_file i_reg_file (
        .clk         (clk),
        .rst         (rst),
        .rs1         (instr[19:15]),
        .rs2         (instr[24:20]),
        .a           (rf_a),
        .b           (rf_b),
        .wb_regwrite (wb_regwrite),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    imm_gen i_imm_gen (
        .instr     (instr),
        .immediate (imm)
    );

    hazard_control i_hazard_control (
        .instr    (instr),
        .idex     (idex.hazard),
        .pcsrc    (pcsrc),
        .branch   (dec_branch),
        .memread  (dec_memread),
        .memtoreg (dec_memtoreg),
        .memwrite (dec_memwrite),
        .alusrc   (dec_alusrc),
        .regwrite (dec_regwrite),
        .aluop    (dec_aluop),
        .stall    (stall),
        .bubble   (bubble)
    );

    id_ex_reg i_id_ex_reg (
        .clk       (clk),
        .rst       (rst),
        .bubble    (bubble),
        .branch    (dec_branch),
        .memread   (dec_memread),
        .memtoreg  (dec_memtoreg),
        .memwrite  (dec_memwrite),
        .alusrc    (dec_alusrc),
        .regwrite  (dec_regwrite),
        .aluop     (dec_aluop),
        .pc        (pc_in),
        .a         (rf_a),
        .b         (rf_b),
        .immediate (imm),
        .func3     (instr[14:12]),
        .func7     (instr[30]),
        .rd        (instr[11:7]),
        .rs1       (instr[19:15]),
        .rs2       (instr[24:20]),
        .idex      (idex.stage)
    );

    execute_stage i_execute_stage (
        .clk           (clk),
        .rst           (rst),
        .idex          (idex.exec),
        .wb_regwrite   (wb_regwrite),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .pcsrc         (pcsrc),
        .branch_target (branch_target),
        .ex_regwrite   (ex_regwrite),
        .ex_memread    (ex_memread),
        .ex_memwrite   (ex_memwrite),
        .ex_memtoreg   (ex_memtoreg),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data)
    );

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    id_ex_if.exec                  idex,
    input  logic                   wb_regwrite,
    input  rv_pipe_pkg::reg_addr_t wb_rd,
    input  rv_pipe_pkg::word_t     wb_data,
    output logic                   pcsrc,
    output rv_pipe_pkg::word_t     branch_target,
    output logic                   ex_regwrite,
    output logic                   ex_memread,
    output logic                   ex_memwrite,
    output logic                   ex_memtoreg,
    output rv_pipe_pkg::reg_addr_t ex_rd,
    output rv_pipe_pkg::word_t     ex_result,
    output rv_pipe_pkg::word_t     ex_store_data
);

    rv_pipe_pkg::word_t    fwd_a;
    rv_pipe_pkg::word_t    fwd_b;
    rv_pipe_pkg::word_t    alu_b;
    rv_pipe_pkg::word_t    alu_result;
    rv_pipe_pkg::alu_ctrl_t alu_ctrl;

    // ========================================================================
    // Forwarding
    // ========================================================================
    // EX/MEM first, then the writeback port. A load in EX/MEM has no data yet.
    function automatic rv_pipe_pkg::word_t forward(input rv_pipe_pkg::reg_addr_t rs,
                                                   input rv_pipe_pkg::word_t id_val);
        if (ex_regwrite && !ex_memread && (ex_rd != '0) && (ex_rd == rs))
            return ex_result;
        else if (wb_regwrite && (wb_rd != '0) && (wb_rd == rs))
            return wb_data;
        else
            return id_val;
    endfunction

    always_comb
    begin
        fwd_a = forward(idex.rs1, idex.a);
        fwd_b = forward(idex.rs2, idex.b);
    end

    assign alu_b = idex.alusrc ? idex.immediate : fwd_b;

    // ========================================================================
    // ALU control and ALU
    // ========================================================================
    always_comb
    begin
        case (idex.func3)
            3'b001:  alu_ctrl = rv_pipe_pkg::ALU_SLL;
            3'b010:  alu_ctrl = rv_pipe_pkg::ALU_SLT;
            3'b100:  alu_ctrl = rv_pipe_pkg::ALU_XOR;
            3'b101:  alu_ctrl = rv_pipe_pkg::ALU_SRL;
            3'b110:  alu_ctrl = rv_pipe_pkg::ALU_OR;
            3'b111:  alu_ctrl = rv_pipe_pkg::ALU_AND;
            default: alu_ctrl = rv_pipe_pkg::ALU_ADD;
        endcase
        if (idex.aluop == rv_pipe_pkg::ALUOP_MEM)
            alu_ctrl = rv_pipe_pkg::ALU_ADD;
        else if (idex.aluop == rv_pipe_pkg::ALUOP_BRANCH)
            alu_ctrl = rv_pipe_pkg::ALU_SUB;
        else if ((idex.aluop == rv_pipe_pkg::ALUOP_RTYPE) && (idex.func3 == 3'b000) &&
                 idex.func7)
            alu_ctrl = rv_pipe_pkg::ALU_SUB;   // I-type bit 30 is part of the immediate.
    end

    always_comb
    begin
        case (alu_ctrl)
            rv_pipe_pkg::ALU_AND: alu_result = fwd_a & alu_b;
            rv_pipe_pkg::ALU_OR:  alu_result = fwd_a | alu_b;
            rv_pipe_pkg::ALU_XOR: alu_result = fwd_a ^ alu_b;
            rv_pipe_pkg::ALU_SUB: alu_result = fwd_a - alu_b;
            rv_pipe_pkg::ALU_SLT: alu_result = {31'b0, $signed(fwd_a) < $signed(alu_b)};
            rv_pipe_pkg::ALU_SLL: alu_result = fwd_a << alu_b[4:0];
            rv_pipe_pkg::ALU_SRL: alu_result = fwd_a >> alu_b[4:0];
            default:              alu_result = fwd_a + alu_b;
        endcase
    end

    // beq is taken when the subtract gives zero.
    assign pcsrc         = idex.branch && (alu_result == '0);
    assign branch_target = idex.pc + idex.immediate;

    // ========================================================================
    // EX/MEM register
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ex_regwrite   <= 1'b0;
            ex_memread    <= 1'b0;
            ex_memwrite   <= 1'b0;
            ex_memtoreg   <= 1'b0;
            ex_rd         <= '0;
            ex_result     <= '0;
            ex_store_data <= '0;
        end
        else
        begin
            ex_regwrite   <= idex.regwrite;
            ex_memread    <= idex.memread;
            ex_memwrite   <= idex.memwrite;
            ex_memtoreg   <= idex.memtoreg;
            ex_rd         <= idex.rd;
            ex_result     <= alu_result;
            ex_store_data <= fwd_b;          // Store data sees forwarding too.
        end
    end

endmodule

// ==== hazard_control.sv ====
`timescale 1ns/1ps

module hazard_control (
    input  rv_pipe_pkg::instr_t  instr,
    id_ex_if.hazard              idex,
    input  logic                 pcsrc,
    output logic                 branch,
    output logic                 memread,
    output logic                 memtoreg,
    output logic                 memwrite,
    output logic                 alusrc,
    output logic                 regwrite,
    output rv_pipe_pkg::aluop_t  aluop,
    output logic                 stall,
    output logic                 bubble
);

    logic [6:0]             opcode;
    rv_pipe_pkg::reg_addr_t rs1;
    rv_pipe_pkg::reg_addr_t rs2;
    logic                   uses_rs2;
    logic                   load_use;

    assign opcode = instr[6:0];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // ========================================================================
    // Main decoder
    // ========================================================================
    always_comb
    begin
        branch   = 1'b0;   // Defaults hold for unknown opcodes.
        memread  = 1'b0;
        memtoreg = 1'b0;
        memwrite = 1'b0;
        alusrc   = 1'b0;
        regwrite = 1'b0;
        aluop    = rv_pipe_pkg::ALUOP_MEM;
        case (opcode)
            rv_pipe_pkg::OPC_RTYPE:
            begin
                regwrite = 1'b1;
                aluop    = rv_pipe_pkg::ALUOP_RTYPE;
            end
            rv_pipe_pkg::OPC_ITYPE:
            begin
                alusrc   = 1'b1;
                regwrite = 1'b1;
                aluop    = rv_pipe_pkg::ALUOP_ITYPE;
            end
            rv_pipe_pkg::OPC_LOAD:
            begin
                memread  = 1'b1;
                memtoreg = 1'b1;
                alusrc   = 1'b1;
                regwrite = 1'b1;
            end
            rv_pipe_pkg::OPC_STORE:
            begin
                memwrite = 1'b1;
                alusrc   = 1'b1;
            end
            rv_pipe_pkg::OPC_BRANCH:
            begin
                branch = 1'b1;
                aluop  = rv_pipe_pkg::ALUOP_BRANCH;
            end
        endcase
    end

    // ========================================================================
    // Load-use detection
    // ========================================================================
    assign uses_rs2 = (opcode == rv_pipe_pkg::OPC_RTYPE) ||
                      (opcode == rv_pipe_pkg::OPC_STORE) ||
                      (opcode == rv_pipe_pkg::OPC_BRANCH);

    assign load_use = idex.memread && (idex.rd != '0) &&
                      ((idex.rd == rs1) || (uses_rs2 && (idex.rd == rs2)));

    // A taken branch squashes decode, so no stall is needed then.
    assign stall  = load_use && !pcsrc;
    assign bubble = stall || pcsrc;

endmodule

// ==== id_ex_if.sv ====
`timescale 1ns/1ps

interface id_ex_if;

    // Control bits
    logic                   branch;
    logic                   memread;
    logic                   memtoreg;
    logic                   memwrite;
    logic                   alusrc;
    logic                   regwrite;
    rv_pipe_pkg::aluop_t    aluop;

    // Payload
    rv_pipe_pkg::word_t     pc;
    rv_pipe_pkg::word_t     a;
    rv_pipe_pkg::word_t     b;
    rv_pipe_pkg::word_t     immediate;
    logic [2:0]             func3;
    logic                   func7;         // Instruction bit 30.
    rv_pipe_pkg::reg_addr_t rd;
    rv_pipe_pkg::reg_addr_t rs1;
    rv_pipe_pkg::reg_addr_t rs2;

    modport stage (output branch, memread, memtoreg, memwrite, alusrc, regwrite, aluop,
                   pc, a, b, immediate, func3, func7, rd, rs1, rs2);

    modport exec (input branch, memread, memtoreg, memwrite, alusrc, regwrite, aluop,
                  pc, a, b, immediate, func3, func7, rd, rs1, rs2);

    modport hazard (input rd, memread);

endinterface

// ==== id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bubble,
    input  logic                   branch,
    input  logic                   memread,
    input  logic                   memtoreg,
    input  logic                   memwrite,
    input  logic                   alusrc,
    input  logic                   regwrite,
    input  rv_pipe_pkg::aluop_t    aluop,
    input  rv_pipe_pkg::word_t     pc,
    input  rv_pipe_pkg::word_t     a,
    input  rv_pipe_pkg::word_t     b,
    input  rv_pipe_pkg::word_t     immediate,
    input  logic [2:0]             func3,
    input  logic                   func7,
    input  rv_pipe_pkg::reg_addr_t rd,
    input  rv_pipe_pkg::reg_addr_t rs1,
    input  rv_pipe_pkg::reg_addr_t rs2,
    id_ex_if.stage                 idex
);

    always_ff @(posedge clk)
    begin
        if (rst || bubble)
        begin
            idex.branch    <= 1'b0;   // Bubble is an all-zero entry.
            idex.memread   <= 1'b0;
            idex.memtoreg  <= 1'b0;
            idex.memwrite  <= 1'b0;
            idex.alusrc    <= 1'b0;
            idex.regwrite  <= 1'b0;
            idex.aluop     <= '0;
            idex.pc        <= '0;
            idex.a         <= '0;
            idex.b         <= '0;
            idex.immediate <= '0;
            idex.func3     <= '0;
            idex.func7     <= 1'b0;
            idex.rd        <= '0;
            idex.rs1       <= '0;
            idex.rs2       <= '0;
        end
        else
        begin
            idex.branch    <= branch;
            idex.memread   <= memread;
            idex.memtoreg  <= memtoreg;
            idex.memwrite  <= memwrite;
            idex.alusrc    <= alusrc;
            idex.regwrite  <= regwrite;
            idex.aluop     <= aluop;
            idex.pc        <= pc;
            idex.a         <= a;
            idex.b         <= b;
            idex.immediate <= immediate;
            idex.func3     <= func3;
            idex.func7     <= func7;
            idex.rd        <= rd;
            idex.rs1       <= rs1;
            idex.rs2       <= rs2;
        end
    end

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  rv_pipe_pkg::instr_t instr,
    output rv_pipe_pkg::word_t  immediate
);

    logic [6:0] opcode;

    assign opcode = instr[6:0];

    always_comb
    begin
        case (opcode)
            rv_pipe_pkg::OPC_ITYPE,
            rv_pipe_pkg::OPC_LOAD:
                immediate = {{20{instr[31]}}, instr[31:20]};
            rv_pipe_pkg::OPC_STORE:
                immediate = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pipe_pkg::OPC_BRANCH:
                // Branch offsets are in half words.
                immediate = {{19{instr[31]}}, instr[31], instr[7],
                             instr[30:25], instr[11:8], 1'b0};
            default:
                immediate = '0;   // R-type has no immediate.
        endcase
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::reg_addr_t rs1,
    input  rv_pipe_pkg::reg_addr_t rs2,
    output rv_pipe_pkg::word_t     a,
    output rv_pipe_pkg::word_t     b,
    input  logic                   wb_regwrite,
    input  rv_pipe_pkg::reg_addr_t wb_rd,
    input  rv_pipe_pkg::word_t     wb_data
);

    rv_pipe_pkg::word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_regwrite && (wb_rd != '0))
        begin
            regs[wb_rd] <= wb_data;   // x0 never written.
        end
    end

    // Reads see a write of the same cycle.
    assign a = (rs1 == '0) ? '0 :
               (wb_regwrite && (wb_rd == rs1)) ? wb_data : regs[rs1];

    assign b = (rs2 == '0) ? '0 :
               (wb_regwrite && (wb_rd == rs2)) ? wb_data : regs[rs2];

endmodule

// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // ========================================================================
    // Types
    // ========================================================================
    typedef logic [31:0] word_t;         // Data word, PC or immediate.
    typedef logic [4:0]  reg_addr_t;     // Register index.
    typedef logic [31:0] instr_t;
    typedef logic [1:0]  aluop_t;        // Class code from the main decoder.
    typedef logic [3:0]  alu_ctrl_t;     // ALU operation select.

    // ========================================================================
    // Opcodes
    // ========================================================================
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Main decoder classes
    localparam aluop_t ALUOP_MEM    = 2'b00;   // Address add.
    localparam aluop_t ALUOP_BRANCH = 2'b01;   // Compare by subtract.
    localparam aluop_t ALUOP_RTYPE  = 2'b10;
    localparam aluop_t ALUOP_ITYPE  = 2'b11;

    // ========================================================================
    // ALU operations
    // ========================================================================
    localparam alu_ctrl_t ALU_AND = 4'b0000;
    localparam alu_ctrl_t ALU_OR  = 4'b0001;
    localparam alu_ctrl_t ALU_ADD = 4'b0010;
    localparam alu_ctrl_t ALU_XOR = 4'b0011;
    localparam alu_ctrl_t ALU_SLL = 4'b0100;
    localparam alu_ctrl_t ALU_SRL = 4'b0101;
    localparam alu_ctrl_t ALU_SUB = 4'b0110;
    localparam alu_ctrl_t ALU_SLT = 4'b0111;

endpackage

// ==== tb_decode_execute.sv ====
`timescale 1ns/1ps

module tb_decode_execute;

    typedef logic [235:0] case_t;   // One cycle of stimulus and expected outputs.

    localparam int    MAX_CASES    = 256;
    localparam int    RESET_CYCLES = 10;
    localparam int    SPARE_CYCLES = 10;
    localparam time   CLK_PERIOD   = 20ns;
    localparam time   DRIVE_DELAY  = 2ns;
    localparam time   SAMPLE_AHEAD = 2ns;   // Compare this long before the next edge.
    localparam string CASES_FILE   = "decode_execute_cases.txt";

    logic                   clk;
    logic                   rst;
    rv_pipe_pkg::instr_t    instr;
    rv_pipe_pkg::word_t     pc_in;
    logic                   wb_regwrite;
    rv_pipe_pkg::reg_addr_t wb_rd;
    rv_pipe_pkg::word_t     wb_data;
    logic                   stall;
    logic                   pcsrc;
    rv_pipe_pkg::word_t     branch_target;
    logic                   ex_regwrite;
    logic                   ex_memread;
    logic                   ex_memwrite;
    logic                   ex_memtoreg;
    rv_pipe_pkg::reg_addr_t ex_rd;
    rv_pipe_pkg::word_t     ex_result;
    rv_pipe_pkg::word_t     ex_store_data;

    case_t cases [MAX_CASES];
    int    num_cases;
    int    row_idx;
    int    fd;
    int    checks      = 0;
    int    word_errors = 0;
    int    addr_errors = 0;
    int    flag_errors = 0;
    logic  loaded      = 1'b0;

    decode_execute_top i_decode_execute_top (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .pc_in         (pc_in),
        .wb_regwrite   (wb_regwrite),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .stall         (stall),
        .pcsrc         (pcsrc),
        .branch_target (branch_target),
        .ex_regwrite   (ex_regwrite),
        .ex_memread    (ex_memread),
        .ex_memwrite   (ex_memwrite),
        .ex_memtoreg   (ex_memtoreg),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data)
    );

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_word(input string name, input rv_pipe_pkg::word_t actual,
                              input rv_pipe_pkg::word_t expected);
        checks++;
        if (actual !== expected)
        begin
            word_errors++;
            $display("error at %t: row %0d, %s expected %h, got %h",
                     $time, row_idx, name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input rv_pipe_pkg::reg_addr_t actual,
                              input rv_pipe_pkg::reg_addr_t expected);
        checks++;
        if (actual !== expected)
        begin
            addr_errors++;
            $display("error at %t: row %0d, %s expected x%0d, got x%0d",
                     $time, row_idx, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected)
        begin
            flag_errors++;
            $display("error at %t: row %0d, %s expected %b, got %b",
                     $time, row_idx, name, expected, actual);
        end
    endtask

    // ========================================================================
    // Row fields from the top are instr, pc_in, wb_regwrite, wb_rd, wb_data,
    // stall, pcsrc, branch_target, four ex controls, ex_rd, ex_result and store data
    // ========================================================================
    task automatic drive_inputs(input case_t row);
        instr       = row[235:204];
        pc_in       = row[203:172];
        wb_regwrite = row[168];
        wb_rd       = row[164:160];
        wb_data     = row[159:128];
    endtask

    task automatic compare_outputs(input case_t row);
        check_flag("stall", stall, row[124]);
        check_flag("pcsrc", pcsrc, row[120]);
        check_word("branch_target", branch_target, row[119:88]);
        check_flag("ex_regwrite", ex_regwrite, row[84]);
        check_flag("ex_memread", ex_memread, row[80]);
        check_flag("ex_memwrite", ex_memwrite, row[76]);
        check_flag("ex_memtoreg", ex_memtoreg, row[72]);
        check_addr("ex_rd", ex_rd, row[68:64]);
        check_word("ex_result", ex_result, row[63:32]);
        check_word("ex_store_data", ex_store_data, row[31:0]);
    endtask

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Limit follows the number of rows in the cases file.
    initial
    begin
        wait (loaded);
        #((RESET_CYCLES + num_cases + SPARE_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not complete within %0d cycles",
                 RESET_CYCLES + num_cases + SPARE_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        rst         = 1'b1;
        instr       = '0;
        pc_in       = '0;
        wb_regwrite = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        row_idx     = 0;
        fd = $fopen(CASES_FILE, "r");
        if (fd != 0)
        begin
            $fclose(fd);
            $readmemh(CASES_FILE, cases);
        end
        num_cases = 0;
        while ((num_cases < MAX_CASES) && !$isunknown(cases[num_cases]))
        begin
            num_cases++;
        end
        if (num_cases == 0)
        begin
            $display("The cases file %s is missing or holds no rows", CASES_FILE);
            $display("Finished with errors");
            $finish;
        end
        else
        begin
            loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #(DRIVE_DELAY);
            rst = 1'b0;
            for (int i = 0; i < num_cases; i++)
            begin
                row_idx = i;
                drive_inputs(cases[i]);
                #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_AHEAD);
                compare_outputs(cases[i]);
                @(posedge clk);
                #(DRIVE_DELAY);
            end
            $display("Rows: %0d, checks: %0d, errors: %0d (word %0d, addr %0d, flag %0d)",
                     num_cases, checks, word_errors + addr_errors + flag_errors,
                     word_errors, addr_errors, flag_errors);
            if ((word_errors + addr_errors + flag_errors) == 0)
                $display("Finished with no errors");
            else
                $display("Finished with errors");
            $finish;
        end
    end

endmodule
